/* de10lite_mmio.f */
design/fabric_pkg.sv
design/mmio_cr_pkg.sv
design/board_input_sync.sv
design/mmio_req_stage.sv
design/mmio_cr_regs.sv
design/mmio_rsp_stage.sv
design/de10lite_mmio.sv
dv/clk_rst_gen.sv
dv/de10lite_mmio_properties.sv
dv/de10lite_mmio_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the MMIO tile testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f de10lite_mmio.f \
    --top-module de10lite_mmio_tb \
    -Mdir obj_dir -o de10lite_mmio_sim

out=$(./obj_dir/de10lite_mmio_sim)
printf '%s\n' "$out"

# Pass only when the testbench reports it
printf '%s\n' "$out" | grep -qx "Result: PASSED"

/* dv/de10lite_mmio_tb.sv */
// MMIO tile testbench
// Table of fabric requests, register model and in-order response scoreboard
`timescale 1ns/1ps

module de10lite_mmio_tb
    import fabric_pkg::*;
    import mmio_cr_pkg::*;
();

    // One table row and scoreboard entry
    typedef struct packed {
        t_opcode op;
        t_addr   addr;
        t_data   wdata;
        logic    btn0;
        logic    btn1;
        t_switch sw;
        t_opcode exp_op;
        t_data   exp_data;
        int      gap;
    } t_row;

    logic    clk_50;
    logic    rst_n;
    logic    f2c_req_valid;
    t_opcode f2c_req_opcode;
    t_addr   f2c_req_address;
    t_data   f2c_req_data;
    logic    f2c_rsp_valid;
    t_opcode f2c_rsp_opcode;
    t_addr   f2c_rsp_address;
    t_data   f2c_rsp_data;
    logic    button_0;
    logic    button_1;
    t_switch switch;
    // Digits 0..5 then the LED bank
    t_seg7   board_out [7];

    t_row    table_rows [80];
    int      n_rows;
    t_row    exp_q [$];
    // Model at table build time and at drive time
    t_seg7   model_rw [7];
    t_seg7   board_rw [7];
    // Pins of the row being built and pins already visible to a read
    logic    cur_btn0;
    logic    cur_btn1;
    t_switch cur_sw;
    logic    vis_btn0;
    logic    vis_btn1;
    t_switch vis_sw;
    int      mismatch_count;
    int      other_count;

    clk_rst_gen u_clk (
        .clk_50 (clk_50),
        .rst_n  (rst_n)
    );

    de10lite_mmio u_dut (
        .clk_50          (clk_50),
        .rst_n           (rst_n),
        .f2c_req_valid   (f2c_req_valid),
        .f2c_req_opcode  (f2c_req_opcode),
        .f2c_req_address (f2c_req_address),
        .f2c_req_data    (f2c_req_data),
        .f2c_rsp_valid   (f2c_rsp_valid),
        .f2c_rsp_opcode  (f2c_rsp_opcode),
        .f2c_rsp_address (f2c_rsp_address),
        .f2c_rsp_data    (f2c_rsp_data),
        .button_0        (button_0),
        .button_1        (button_1),
        .switch          (switch),
        .seg7_0          (board_out[0]),
        .seg7_1          (board_out[1]),
        .seg7_2          (board_out[2]),
        .seg7_3          (board_out[3]),
        .seg7_4          (board_out[4]),
        .seg7_5          (board_out[5]),
        .led             (board_out[6])
    );

    // --------------------
    // Model
    // --------------------

    // Read-write registers sit one word apart from offset 0
    // Any other offset gives -1
    function automatic int rw_index(t_cr_offset offset);
        if (offset <= CR_LED && offset[1:0] == 2'b00) begin
            return int'(offset >> 2);
        end
        return -1;
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED t=%0t %s: got 0x%08h expected 0x%08h",
                $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_board();
        int k;
        for (k = 0; k < 7; k++) begin
            check_value((k == 6) ? "led" : $sformatf("seg7_%0d", k),
                32'(board_out[k]), 32'(board_rw[k]));
        end
    endtask

    // Expected response follows the register map and the model so far
    task automatic add_row(t_opcode op, t_cr_offset offset, t_data wdata, int gap);
        t_row row;
        int   idx;
        idx          = rw_index(offset);
        row.op       = op;
        row.addr     = {12'h800, offset};
        row.wdata    = wdata;
        row.btn0     = cur_btn0;
        row.btn1     = cur_btn1;
        row.sw       = cur_sw;
        row.gap      = gap;
        row.exp_data = '0;
        // Response opcodes sent as requests are dropped and expect nothing
        row.exp_op   = op;
        if (op == WR) begin
            row.exp_op = WR_RSP;
            if (idx >= 0) begin
                model_rw[idx] = wdata[SEG7_W-1:0];
            end
        end else if (op == RD) begin
            row.exp_op = RD_RSP;
            if (idx >= 0) begin
                row.exp_data = t_data'(model_rw[idx]);
            end else if (offset == CR_BUTTON_0) begin
                row.exp_data = t_data'(vis_btn0);
            end else if (offset == CR_BUTTON_1) begin
                row.exp_data = t_data'(vis_btn1);
            end else if (offset == CR_SWITCH) begin
                row.exp_data = t_data'(vis_sw);
            end
        end
        // New pins only reach a later read
        vis_btn0 = cur_btn0;
        vis_btn1 = cur_btn1;
        vis_sw   = cur_sw;
        table_rows[n_rows] = row;
        n_rows++;
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic build_table();
        int i;
        n_rows = 0;
        // Reset values
        for (i = 0; i < 7; i++) begin
            add_row(RD, t_cr_offset'(4 * i), '0, 3);
        end
        // Random writes then read back
        for (i = 0; i < 7; i++) begin
            add_row(WR, t_cr_offset'(4 * i), $urandom, 3);
        end
        for (i = 0; i < 7; i++) begin
            add_row(RD, t_cr_offset'(4 * i), '0, 2);
        end
        // Board pins change with an unmapped read
        cur_btn0 = 1'b1;
        cur_btn1 = 1'b0;
        cur_sw   = 10'h2A5;
        add_row(RD, 20'h00200, '0, 5);
        add_row(RD, CR_BUTTON_0, '0, 2);
        add_row(RD, CR_BUTTON_1, '0, 2);
        add_row(RD, CR_SWITCH, '0, 2);
        cur_btn0 = 1'b0;
        cur_btn1 = 1'b1;
        cur_sw   = 10'h15A;
        // Read in the cycle of the change sees the old pins
        add_row(RD, CR_SWITCH, '0, 5);
        add_row(RD, CR_BUTTON_0, '0, 2);
        add_row(RD, CR_BUTTON_1, '0, 2);
        add_row(RD, CR_SWITCH, '0, 2);
        // Writes that change nothing
        add_row(WR, 20'h0001C, $urandom, 3);
        add_row(WR, CR_SWITCH, $urandom, 3);
        add_row(WR, CR_BUTTON_1, $urandom, 3);
        // Dropped request opcodes, new data would show in the read-back
        add_row(WR_RSP, CR_SEG7_0, t_data'(~model_rw[0]), 3);
        add_row(RD_RSP, CR_SEG7_1, '0, 3);
        add_row(RD, 20'hFFFFC, '0, 2);
        for (i = 0; i < 7; i++) begin
            add_row(RD, t_cr_offset'(4 * i), '0, 2);
        end
        add_row(RD, CR_SWITCH, '0, 2);
        // Back-to-back write and read pairs and a read burst
        for (i = 0; i < 7; i++) begin
            add_row(WR, t_cr_offset'(4 * i), $urandom, 1);
            add_row(RD, t_cr_offset'(4 * i), '0, 1);
        end
        for (i = 0; i < 7; i++) begin
            add_row(RD, t_cr_offset'(4 * i), '0, 1);
        end
        add_row(RD, CR_SWITCH, '0, 4);
    endtask

    // --------------------
    // Driver
    // --------------------
    task automatic apply_row(t_row row);
        int j;
        int idx;
        @(posedge clk_50);
        #1;
        f2c_req_valid   = 1'b1;
        f2c_req_opcode  = row.op;
        f2c_req_address = row.addr;
        f2c_req_data    = row.wdata;
        button_0        = row.btn0;
        button_1        = row.btn1;
        switch          = row.sw;
        if (row.op == RD || row.op == WR) begin
            exp_q.push_back(row);
        end
        idx = rw_index(row.addr[CR_OFFSET_W-1:0]);
        if (row.op == WR && idx >= 0) begin
            board_rw[idx] = row.wdata[SEG7_W-1:0];
        end
        for (j = 1; j < row.gap; j++) begin
            @(posedge clk_50);
            #1;
            f2c_req_valid = 1'b0;
            // Write lands two edges after it is driven
            if (j == 2 && row.op == WR) begin
                check_board();
            end
        end
    endtask

    // --------------------
    // Scoreboard
    // --------------------
    initial begin : response_monitor
        t_row expected_rsp;
        forever begin
            @(negedge clk_50);
            if (rst_n && f2c_rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Response at t=%0t with no request outstanding", $time);
                    other_count++;
                end else begin
                    expected_rsp = exp_q.pop_front();
                    check_value("f2c_rsp_opcode", 32'(f2c_rsp_opcode),
                        32'(expected_rsp.exp_op));
                    check_value("f2c_rsp_address", f2c_rsp_address, expected_rsp.addr);
                    check_value("f2c_rsp_data", f2c_rsp_data, expected_rsp.exp_data);
                end
            end
        end
    end

    initial begin
        int cycles;
        int r;
        f2c_req_valid   = 1'b0;
        f2c_req_opcode  = RD;
        f2c_req_address = '0;
        f2c_req_data    = '0;
        button_0        = 1'b0;
        button_1        = 1'b0;
        switch          = '0;
        mismatch_count  = 0;
        other_count     = 0;
        model_rw        = '{default: '0};
        board_rw        = '{default: '0};
        cur_btn0        = 1'b0;
        cur_btn1        = 1'b0;
        cur_sw          = '0;
        vis_btn0        = 1'b0;
        vis_btn1        = 1'b0;
        vis_sw          = '0;
        void'($urandom(32'h3705_543c));
        build_table();

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 20) begin
            @(posedge clk_50);
            cycles++;
        end
        #1;
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            other_count++;
        end else begin
            // Idle response and cleared board outputs
            check_value("f2c_rsp_valid", 32'(f2c_rsp_valid), 32'h0);
            check_board();
            for (r = 0; r < n_rows; r++) begin
                apply_row(table_rows[r]);
            end
            // Drain the pipeline
            cycles = 0;
            while (exp_q.size() != 0 && cycles < 10) begin
                @(posedge clk_50);
                cycles++;
            end
            if (exp_q.size() != 0) begin
                $display("Timed out waiting for %0d responses", exp_q.size());
                other_count++;
            end
            check_board();
        end

        $display("Errors: %0d value mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* dv/de10lite_mmio_properties.sv */
// MMIO tile properties
// Response timing against the request and output state right after reset
`timescale 1ns/1ps

module de10lite_mmio_properties
    import fabric_pkg::*;
    import mmio_cr_pkg::*;
(
    input logic    clk_50,
    input logic    rst_n,
    input logic    f2c_req_valid,
    input t_opcode f2c_req_opcode,
    input logic    f2c_rsp_valid,
    input t_seg7   seg7_0,
    input t_seg7   seg7_1,
    input t_seg7   seg7_2,
    input t_seg7   seg7_3,
    input t_seg7   seg7_4,
    input t_seg7   seg7_5,
    input t_seg7   led
);

    // Request that must be answered
    logic req_ok;

    assign req_ok = f2c_req_valid && (f2c_req_opcode == RD || f2c_req_opcode == WR);

    // --------------------
    // Response timing
    // --------------------

    // Sample, access, output
    assert property (@(posedge clk_50) disable iff (!rst_n)
        $past(req_ok, 3) |-> f2c_rsp_valid)
        else $error("No response three cycles after a request");

    // Nothing answers a dropped or absent request
    assert property (@(posedge clk_50) disable iff (!rst_n)
        f2c_rsp_valid |-> $past(req_ok, 3))
        else $error("Response without a request three cycles earlier");

    // Outputs cleared when reset goes away
    assert property (@(posedge clk_50)
        $rose(rst_n) |-> !f2c_rsp_valid
            && ({seg7_0, seg7_1, seg7_2, seg7_3, seg7_4, seg7_5, led} == '0))
        else $error("Outputs not zero after reset");

endmodule

bind de10lite_mmio de10lite_mmio_properties u_props (
    .clk_50         (clk_50),
    .rst_n          (rst_n),
    .f2c_req_valid  (f2c_req_valid),
    .f2c_req_opcode (f2c_req_opcode),
    .f2c_rsp_valid  (f2c_rsp_valid),
    .seg7_0         (seg7_0),
    .seg7_1         (seg7_1),
    .seg7_2         (seg7_2),
    .seg7_3         (seg7_3),
    .seg7_4         (seg7_4),
    .seg7_5         (seg7_5),
    .led            (led)
);

/* dv/clk_rst_gen.sv */
// Testbench clock and reset
// 10 ns clock, reset held low for five rising edges
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clk_50,
    output logic rst_n
);

    initial begin
        clk_50 = 1'b0;
        forever begin
            #5 clk_50 = ~clk_50;
        end
    end

    // Release just after the fifth edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk_50);
        #1 rst_n = 1'b1;
    end

endmodule

/* design/de10lite_mmio.sv */
// DE10-Lite MMIO tile top
// Fabric request in, three-stage register access, fabric response out
`timescale 1ns/1ps

module de10lite_mmio
    import fabric_pkg::*;
    import mmio_cr_pkg::*;
(
    input  logic    clk_50,
    input  logic    rst_n,
    // Fabric request
    input  logic    f2c_req_valid,
    input  t_opcode f2c_req_opcode,
    input  t_addr   f2c_req_address,
    input  t_data   f2c_req_data,
    // Fabric response
    output logic    f2c_rsp_valid,
    output t_opcode f2c_rsp_opcode,
    output t_addr   f2c_rsp_address,
    output t_data   f2c_rsp_data,
    // Board inputs
    input  logic    button_0,
    input  logic    button_1,
    input  t_switch switch,
    // Board outputs
    output t_seg7   seg7_0,
    output t_seg7   seg7_1,
    output t_seg7   seg7_2,
    output t_seg7   seg7_3,
    output t_seg7   seg7_4,
    output t_seg7   seg7_5,
    output t_seg7   led
);

    // Sampled request
    logic    rd_en;
    logic    wr_en;
    t_addr   req_address;
    t_data   req_data;
    // Register file read
    t_data   rd_data;
    // Synchronized board inputs
    logic    button_0_sync;
    logic    button_1_sync;
    t_switch switch_sync;

    // --------------------
    // Board inputs
    // --------------------
    board_input_sync u_sync (
        .clk_50        (clk_50),
        .rst_n         (rst_n),
        .button_0      (button_0),
        .button_1      (button_1),
        .switch        (switch),
        .button_0_sync (button_0_sync),
        .button_1_sync (button_1_sync),
        .switch_sync   (switch_sync)
    );

    // --------------------
    // Pipeline
    // --------------------

    // Sample
    mmio_req_stage u_req (
        .clk_50          (clk_50),
        .rst_n           (rst_n),
        .f2c_req_valid   (f2c_req_valid),
        .f2c_req_opcode  (f2c_req_opcode),
        .f2c_req_address (f2c_req_address),
        .f2c_req_data    (f2c_req_data),
        .rd_en           (rd_en),
        .wr_en           (wr_en),
        .req_address     (req_address),
        .req_data        (req_data)
    );

    // Register access
    mmio_cr_regs u_regs (
        .clk_50        (clk_50),
        .rst_n         (rst_n),
        .rd_en         (rd_en),
        .wr_en         (wr_en),
        .req_address   (req_address),
        .req_data      (req_data),
        .button_0_sync (button_0_sync),
        .button_1_sync (button_1_sync),
        .switch_sync   (switch_sync),
        .rd_data       (rd_data),
        .seg7_0        (seg7_0),
        .seg7_1        (seg7_1),
        .seg7_2        (seg7_2),
        .seg7_3        (seg7_3),
        .seg7_4        (seg7_4),
        .seg7_5        (seg7_5),
        .led           (led)
    );

    // Access and output flops
    mmio_rsp_stage u_rsp (
        .clk_50          (clk_50),
        .rst_n           (rst_n),
        .rd_en           (rd_en),
        .wr_en           (wr_en),
        .req_address     (req_address),
        .rd_data         (rd_data),
        .f2c_rsp_valid   (f2c_rsp_valid),
        .f2c_rsp_opcode  (f2c_rsp_opcode),
        .f2c_rsp_address (f2c_rsp_address),
        .f2c_rsp_data    (f2c_rsp_data)
    );

endmodule

/* design/mmio_rsp_stage.sv */
// MMIO response stage
// Access and output flops that form the fabric response
`timescale 1ns/1ps

module mmio_rsp_stage
    import fabric_pkg::*;
(
    input  logic    clk_50,
    input  logic    rst_n,
    input  logic    rd_en,
    input  logic    wr_en,
    input  t_addr   req_address,
    input  t_data   rd_data,
    // Fabric response
    output logic    f2c_rsp_valid,
    output t_opcode f2c_rsp_opcode,
    output t_addr   f2c_rsp_address,
    output t_data   f2c_rsp_data
);

    // Access stage copies
    logic  rd_en_q;
    logic  wr_en_q;
    t_addr rsp_address_q;
    t_data rsp_data_q;

    // --------------------
    // Access stage
    // --------------------
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            rd_en_q <= rd_en;
            wr_en_q <= wr_en;
        end
    end

    // Read data is already zero for writes
    always_ff @(posedge clk_50) begin
        rsp_address_q <= req_address;
        rsp_data_q    <= rd_data;
    end

    // --------------------
    // Output stage
    // --------------------
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            f2c_rsp_valid <= 1'b0;
        end else begin
            // One response per read or write
            f2c_rsp_valid <= rd_en_q || wr_en_q;
        end
    end

    // Opcode from the read enable, write otherwise
    always_ff @(posedge clk_50) begin
        f2c_rsp_opcode  <= rd_en_q ? RD_RSP : WR_RSP;
        f2c_rsp_address <= rsp_address_q;
        f2c_rsp_data    <= rsp_data_q;
    end

endmodule

/* design/mmio_cr_regs.sv */
// MMIO control-register file
// Read-write display registers, read-only board input copies and the read mux
`timescale 1ns/1ps

module mmio_cr_regs
    import fabric_pkg::*;
    import mmio_cr_pkg::*;
(
    input  logic    clk_50,
    input  logic    rst_n,
    input  logic    rd_en,
    input  logic    wr_en,
    input  t_addr   req_address,
    input  t_data   req_data,
    // Synchronized board inputs
    input  logic    button_0_sync,
    input  logic    button_1_sync,
    input  t_switch switch_sync,
    // Read data to the response stage
    output t_data   rd_data,
    // Board outputs
    output t_seg7   seg7_0,
    output t_seg7   seg7_1,
    output t_seg7   seg7_2,
    output t_seg7   seg7_3,
    output t_seg7   seg7_4,
    output t_seg7   seg7_5,
    output t_seg7   led
);

    // Decoded offset
    t_cr_offset offset;

    // Read-write registers, entries 0..5 are digits, entry 6 is the LED bank
    t_seg7 rw_q    [7];
    t_seg7 rw_next [7];

    // Read-only copies of the board inputs
    logic    button_0_q;
    logic    button_1_q;
    t_switch switch_q;

    assign offset = req_address[CR_OFFSET_W-1:0];

    // --------------------
    // Write decode
    // --------------------
    always_comb begin
        rw_next = rw_q;
        if (wr_en) begin
            case (offset)
                CR_SEG7_0: rw_next[0] = req_data[SEG7_W-1:0];
                CR_SEG7_1: rw_next[1] = req_data[SEG7_W-1:0];
                CR_SEG7_2: rw_next[2] = req_data[SEG7_W-1:0];
                CR_SEG7_3: rw_next[3] = req_data[SEG7_W-1:0];
                CR_SEG7_4: rw_next[4] = req_data[SEG7_W-1:0];
                CR_SEG7_5: rw_next[5] = req_data[SEG7_W-1:0];
                CR_LED:    rw_next[6] = req_data[SEG7_W-1:0];
                // Read-only and unmapped offsets keep everything
                default: ;
            endcase
        end
    end

    // --------------------
    // Register update
    // --------------------
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            rw_q       <= '{default: '0};
            button_0_q <= 1'b0;
            button_1_q <= 1'b0;
            switch_q   <= '0;
        end else begin
            rw_q       <= rw_next;
            // Board copies reload every cycle
            button_0_q <= button_0_sync;
            button_1_q <= button_1_sync;
            switch_q   <= switch_sync;
        end
    end

    // --------------------
    // Read mux
    // --------------------

    // Next-state view so a read right after a write sees the new value
    always_comb begin
        rd_data = '0;
        if (rd_en) begin
            case (offset)
                CR_SEG7_0:   rd_data = t_data'(rw_next[0]);
                CR_SEG7_1:   rd_data = t_data'(rw_next[1]);
                CR_SEG7_2:   rd_data = t_data'(rw_next[2]);
                CR_SEG7_3:   rd_data = t_data'(rw_next[3]);
                CR_SEG7_4:   rd_data = t_data'(rw_next[4]);
                CR_SEG7_5:   rd_data = t_data'(rw_next[5]);
                CR_LED:      rd_data = t_data'(rw_next[6]);
                CR_BUTTON_0: rd_data = t_data'(button_0_q);
                CR_BUTTON_1: rd_data = t_data'(button_1_q);
                CR_SWITCH:   rd_data = t_data'(switch_q);
                // Unmapped reads return zero
                default:     rd_data = '0;
            endcase
        end
    end

    // Board outputs follow the registered next state
    assign seg7_0 = rw_q[0];
    assign seg7_1 = rw_q[1];
    assign seg7_2 = rw_q[2];
    assign seg7_3 = rw_q[3];
    assign seg7_4 = rw_q[4];
    assign seg7_5 = rw_q[5];
    assign led    = rw_q[6];

endmodule

/* design/mmio_req_stage.sv */
// MMIO request stage
// Samples the fabric request and decodes the read and write enables
`timescale 1ns/1ps

module mmio_req_stage
    import fabric_pkg::*;
(
    input  logic    clk_50,
    input  logic    rst_n,
    // Fabric request
    input  logic    f2c_req_valid,
    input  t_opcode f2c_req_opcode,
    input  t_addr   f2c_req_address,
    input  t_data   f2c_req_data,
    // To register file and response stage
    output logic    rd_en,
    output logic    wr_en,
    output t_addr   req_address,
    output t_data   req_data
);

    // Sampled request
    logic    req_valid_q;
    t_opcode req_opcode_q;

    // --------------------
    // Sample stage
    // --------------------

    // Valid is control, cleared on reset
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= f2c_req_valid;
        end
    end

    // Opcode, address and data only matter with valid
    always_ff @(posedge clk_50) begin
        req_opcode_q <= f2c_req_opcode;
        req_address  <= f2c_req_address;
        req_data     <= f2c_req_data;
    end

    // --------------------
    // Opcode decode
    // --------------------

    // One opcode per request, so never both
    // Response opcodes on the request side fall out here and are dropped
    assign rd_en = req_valid_q && (req_opcode_q == RD);
    assign wr_en = req_valid_q && (req_opcode_q == WR);

endmodule

/* design/board_input_sync.sv */
// Board input synchronizer
// Two flops on each button and switch line before they reach the registers
`timescale 1ns/1ps

module board_input_sync
    import mmio_cr_pkg::*;
(
    input  logic    clk_50,
    input  logic    rst_n,
    input  logic    button_0,
    input  logic    button_1,
    input  t_switch switch,
    output logic    button_0_sync,
    output logic    button_1_sync,
    output t_switch switch_sync
);

    // First stage, may go metastable
    logic    button_0_meta;
    logic    button_1_meta;
    t_switch switch_meta;

    // --------------------
    // Two-flop chain
    // --------------------
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            button_0_meta <= 1'b0;
            button_1_meta <= 1'b0;
            switch_meta   <= '0;
            button_0_sync <= 1'b0;
            button_1_sync <= 1'b0;
            switch_sync   <= '0;
        end else begin
            // Stage one from the pins
            button_0_meta <= button_0;
            button_1_meta <= button_1;
            switch_meta   <= switch;
            // Stage two, settled copy
            button_0_sync <= button_0_meta;
            button_1_sync <= button_1_meta;
            switch_sync   <= switch_meta;
        end
    end

endmodule

/* design/mmio_cr_pkg.sv */
// Control-register package
// Register offsets and board field types of the MMIO tile
package mmio_cr_pkg;

    // --------------------
    // Field widths
    // --------------------

    // One seven-segment digit, LED bank uses the same width
    localparam int SEG7_W = 7;

    // Slide switches
    localparam int SWITCH_W = 10;

    // --------------------
    // Types
    // --------------------

    // Decoded part of the fabric address
    typedef logic [fabric_pkg::CR_OFFSET_W-1:0] t_cr_offset;

    typedef logic [SEG7_W-1:0]   t_seg7;
    typedef logic [SWITCH_W-1:0] t_switch;

    // --------------------
    // Register map
    // --------------------

    // Read-write, one word per digit
    localparam t_cr_offset CR_SEG7_0 = 20'h00000;
    localparam t_cr_offset CR_SEG7_1 = 20'h00004;
    localparam t_cr_offset CR_SEG7_2 = 20'h00008;
    localparam t_cr_offset CR_SEG7_3 = 20'h0000C;
    localparam t_cr_offset CR_SEG7_4 = 20'h00010;
    localparam t_cr_offset CR_SEG7_5 = 20'h00014;
    localparam t_cr_offset CR_LED    = 20'h00018;

    // Read-only board inputs
    localparam t_cr_offset CR_BUTTON_0 = 20'h00100;
    localparam t_cr_offset CR_BUTTON_1 = 20'h00104;
    localparam t_cr_offset CR_SWITCH   = 20'h00108;

endpackage

/* design/fabric_pkg.sv */
// Fabric package
// Request/response opcode and the address and data types shared over the fabric
package fabric_pkg;

    // --------------------
    // Widths
    // --------------------

    // Low address bits that select a control register
    // Upper bits are ignored by the tile
    localparam int CR_OFFSET_W = 20;

    // --------------------
    // Types
    // --------------------

    // Full fabric address
    typedef logic [31:0] t_addr;

    // Fabric data word
    typedef logic [31:0] t_data;

    // Fabric opcode
    // Requests carry RD or WR
    // Responses carry the matching *_RSP code
    typedef enum logic [1:0] {
        RD     = 2'b00,
        RD_RSP = 2'b01,
        WR     = 2'b10,
        WR_RSP = 2'b11
    } t_opcode;

endpackage
